//--- hdl/io_map_pkg.sv
`default_nettype none

package io_map_pkg;

	typedef logic [4:0] io_addr_t;

	localparam io_addr_t REG_TIMER0   = 5'd0;
	localparam io_addr_t REG_TIMER1   = 5'd1;
	localparam io_addr_t REG_TOP0     = 5'd2;
	localparam io_addr_t REG_TOP1     = 5'd3;
	localparam io_addr_t REG_PRE0     = 5'd4;
	localparam io_addr_t REG_PRE1     = 5'd5;
	localparam io_addr_t REG_GPIO_DIR = 5'd11;
	localparam io_addr_t REG_GPIO_DAT = 5'd12;
	localparam io_addr_t REG_GPIO_PIN = 5'd13;
	localparam io_addr_t REG_ALT      = 5'd14;
	localparam io_addr_t REG_INT_CTL  = 5'd15;
	localparam io_addr_t REG_SCRATCH  = 5'd17;
	localparam io_addr_t REG_ID0      = 5'd18;
	localparam io_addr_t REG_ID1      = 5'd19;

	localparam logic [31:0] ID0_VALUE      = 32'h7269_6843;
	localparam logic [31:0] ID1_VALUE      = 32'h0000_2170;
	localparam logic [31:0] UNMAPPED_VALUE = 32'hFFFF_FFFF;

	localparam logic [31:0] PRESCALE_RESET = 32'd100;
	localparam logic [31:0] TOP_RESET      = 32'hFFFF_FFFF;
	localparam logic [7:0]  GPIO_DAT_RESET = 8'h55;
	localparam logic [7:0]  GPIO_DIR_RESET = 8'h00;

	// Bit positions inside the alternate-function register
	localparam int ALT_T1_TOGGLE = 0;
	localparam int ALT_PIN_INT   = 1;
	localparam int ALT_T0_INT    = 2;

	localparam int EDGE_PIN   = 1;
	localparam int TOGGLE_PIN = 0;

endpackage

`default_nettype wire

//--- hdl/io_types_pkg.sv
`default_nettype none

package io_types_pkg;

	// Write layout of the interrupt control register
	typedef struct packed {
		logic [25:0] reserved;
		logic        clr_int2;
		logic        ie_load;
		logic        ie_value;
		logic        set_int2;
		logic        clr_int1;
		logic        clr_int0;
	} int_ctl_t;

	typedef union packed {
		logic [31:0] raw;
		int_ctl_t    ctl;
	} io_word_u;

	typedef logic [1:0] irq_vec_t;

	localparam irq_vec_t VEC_PIN    = 2'd1;
	localparam irq_vec_t VEC_TIMER0 = 2'd2;
	localparam irq_vec_t VEC_SOFT   = 2'd3;

endpackage

`default_nettype wire

//--- hdl/io_bus_if.sv
`default_nettype none

interface io_bus_if;
	import io_map_pkg::*;
	import io_types_pkg::*;

	logic        wen;
	io_addr_t    addr;
	io_word_u    wdata; // Only meaningful while wen is high
	logic [31:0] rdata;

	modport ctrl (output wen, output addr, output wdata, input rdata);

	modport map (input wen, input addr, input wdata, output rdata);

	modport peer (input wen, input addr, input wdata);

endinterface

`default_nettype wire

//--- hdl/bus_slave_fsm.sv
`default_nettype none

module bus_slave_fsm (
	input wire                   clk,
	input wire                   rst,
	input wire                   req,
	input wire                   we,
	input wire io_map_pkg::io_addr_t addr,
	input wire [31:0]            wdata,
	output logic                 ack,
	output logic [31:0]          rdata,
	io_bus_if.ctrl               bus
);
	import io_map_pkg::*;
	import io_types_pkg::*;

	typedef enum logic [1:0] {IDLE, ACCESS, HOLD} state_t;

	state_t   state;
	logic     wen;
	io_addr_t addr_q;
	io_word_u wdata_q;

	assign bus.wen   = wen;
	assign bus.addr  = addr_q;
	assign bus.wdata = wdata_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			wen   <= 1'b0;
			ack   <= 1'b0;
		end else begin
			case (state)
				IDLE: if (req) begin
					state <= ACCESS;
					wen   <= we; // Write strobe lasts exactly the ACCESS cycle
				end
				ACCESS: begin
					state <= HOLD;
					wen   <= 1'b0;
					ack   <= 1'b1;
				end
				HOLD: if (!req) begin
					state <= IDLE;
					ack   <= 1'b0;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && req) begin
			addr_q      <= addr;
			wdata_q.raw <= wdata;
		end
		if (state == ACCESS)
			rdata <= bus.rdata; // Map value before this cycle's write lands
	end

	assert property (@(posedge clk) disable iff (rst) bus.wen |=> !bus.wen);

	// Host must have released req before ack goes away
	assert property (@(posedge clk) disable iff (rst) $fell(ack) |-> $past(!req));

endmodule

`default_nettype wire

//--- hdl/prescaled_timer.sv
`default_nettype none

module prescaled_timer #(
	parameter int TIMER_WIDTH = 32,
	parameter int PRESCALE_WIDTH = 17,
	parameter io_map_pkg::io_addr_t COUNT_REG = io_map_pkg::REG_TIMER0,
	parameter io_map_pkg::io_addr_t TOP_REG = io_map_pkg::REG_TOP0,
	parameter io_map_pkg::io_addr_t PRE_REG = io_map_pkg::REG_PRE0
) (
	input wire                        clk,
	input wire                        rst,
	io_bus_if.peer                    bus,
	output logic [TIMER_WIDTH-1:0]    count,
	output logic [TIMER_WIDTH-1:0]    top,
	output logic [PRESCALE_WIDTH-1:0] prescaler,
	output logic                      wrap
);
	import io_map_pkg::*;

	logic [PRESCALE_WIDTH-1:0] pre_cnt;
	logic                      tick;

	assign tick = (pre_cnt == prescaler);
	assign wrap = tick && (count == top);

	always_ff @(posedge clk) begin
		if (rst) begin
			count     <= '0;
			top       <= TIMER_WIDTH'(TOP_RESET);
			prescaler <= PRESCALE_WIDTH'(PRESCALE_RESET);
			pre_cnt   <= '0;
		end else begin
			pre_cnt <= pre_cnt + 1'b1;
			if (tick) begin
				pre_cnt <= '0;
				count   <= wrap ? '0 : count + 1'b1;
			end
			// Host writes take priority over counting
			if (bus.wen) begin
				case (bus.addr)
					COUNT_REG: count <= bus.wdata.raw[TIMER_WIDTH-1:0];
					TOP_REG: top <= bus.wdata.raw[TIMER_WIDTH-1:0];
					PRE_REG: prescaler <= bus.wdata.raw[PRESCALE_WIDTH-1:0];
					default: ;
				endcase
			end
		end
	end

	assert property (@(posedge clk) disable iff (rst)
		wrap && !(bus.wen && bus.addr == COUNT_REG) |=> count == '0);

endmodule

`default_nettype wire

//--- hdl/gpio_port.sv
`default_nettype none

module gpio_port #(
	parameter int GPIO_WIDTH = 8
) (
	input wire                     clk,
	input wire                     rst,
	io_bus_if.peer                 bus,
	input wire [7:0]               alt,
	input wire                     t1_wrap,
	input wire [GPIO_WIDTH-1:0]    pins,
	output logic [GPIO_WIDTH-1:0]  dir,
	output logic [GPIO_WIDTH-1:0]  dat,
	output logic                   pin_edge
);
	import io_map_pkg::*;

	logic edge_sync;
	logic edge_last;

	always_ff @(posedge clk) begin
		if (rst) begin
			dir       <= GPIO_WIDTH'(GPIO_DIR_RESET);
			dat       <= GPIO_WIDTH'(GPIO_DAT_RESET);
			edge_sync <= 1'b0;
			edge_last <= 1'b0;
			pin_edge  <= 1'b0;
		end else begin
			if (alt[ALT_PIN_INT]) begin
				edge_sync <= pins[EDGE_PIN];
				edge_last <= edge_sync;
			end else begin
				edge_sync <= 1'b0; // Forget history so re-enabling sees a held-high pin
				edge_last <= 1'b0;
			end
			pin_edge <= alt[ALT_PIN_INT] && edge_sync && !edge_last;

			if (t1_wrap && alt[ALT_T1_TOGGLE])
				dat[TOGGLE_PIN] <= ~dat[TOGGLE_PIN];
			if (bus.wen && bus.addr == REG_GPIO_DIR)
				dir <= bus.wdata.raw[GPIO_WIDTH-1:0];
			if (bus.wen && bus.addr == REG_GPIO_DAT)
				dat <= bus.wdata.raw[GPIO_WIDTH-1:0];
		end
	end

endmodule

`default_nettype wire

//--- hdl/irq_ctrl.sv
`default_nettype none

module irq_ctrl (
	input wire                         clk,
	input wire                         rst,
	io_bus_if.peer                     bus,
	input wire [7:0]                   alt,
	input wire                         pin_edge,
	input wire                         t0_wrap,
	input wire                         int_taken,
	input wire                         int_return,
	output logic                       irq,
	output io_types_pkg::irq_vec_t     irq_vector,
	output logic [3:0]                 status
);
	import io_map_pkg::*;
	import io_types_pkg::*;

	int_ctl_t ctl;
	logic     ctl_wr;
	logic     int0;
	logic     int1;
	logic     int2;
	logic     ie;

	assign ctl    = bus.wdata.ctl;
	assign ctl_wr = bus.wen && bus.addr == REG_INT_CTL;

	always_ff @(posedge clk) begin
		if (rst) begin
			int0 <= 1'b0;
			int1 <= 1'b0;
			int2 <= 1'b0;
			ie   <= 1'b0;
		end else begin
			if (pin_edge)
				int0 <= 1'b1;
			if (t0_wrap && alt[ALT_T0_INT])
				int1 <= 1'b1;
			if (ctl_wr) begin
				if (ctl.clr_int0) int0 <= 1'b0;
				if (ctl.clr_int1) int1 <= 1'b0;
				if (ctl.set_int2) int2 <= 1'b1;
				if (ctl.clr_int2) int2 <= 1'b0; // Clear wins over set in one write
				if (ctl.ie_load) ie <= ctl.ie_value;
			end
			if (int_return)
				ie <= 1'b1;
			if (int_taken)
				ie <= 1'b0;
		end
	end

	assign irq    = ie && (int0 || int1 || int2);
	assign status = {ie, int2, int1, int0};

	// Timer0 has the highest priority, then software
	assign irq_vector = int1 ? VEC_TIMER0 : (int2 ? VEC_SOFT : VEC_PIN);

	assert property (@(posedge clk) disable iff (rst) irq |-> ie);

endmodule

`default_nettype wire

//--- hdl/io_regmap.sv
`default_nettype none

module io_regmap #(
	parameter int GPIO_WIDTH = 8,
	parameter int TIMER_WIDTH = 32,
	parameter int PRESCALE_WIDTH = 17
) (
	input wire                      clk,
	input wire                      rst,
	io_bus_if.map                   bus,
	input wire [TIMER_WIDTH-1:0]    timer0,
	input wire [TIMER_WIDTH-1:0]    top0,
	input wire [PRESCALE_WIDTH-1:0] pre0,
	input wire [TIMER_WIDTH-1:0]    timer1,
	input wire [TIMER_WIDTH-1:0]    top1,
	input wire [PRESCALE_WIDTH-1:0] pre1,
	input wire [GPIO_WIDTH-1:0]     gpio_dir,
	input wire [GPIO_WIDTH-1:0]     gpio_dat,
	input wire [GPIO_WIDTH-1:0]     gpio_pins,
	input wire [3:0]                irq_status,
	output logic [7:0]              alt
);
	import io_map_pkg::*;

	logic [31:0] scratch;

	always_ff @(posedge clk) begin
		if (rst)
			alt <= '0;
		else if (bus.wen && bus.addr == REG_ALT)
			alt <= bus.wdata.raw[7:0];
	end

	always_ff @(posedge clk) begin
		if (bus.wen && bus.addr == REG_SCRATCH)
			scratch <= bus.wdata.raw;
	end

	// ID registers ignore writes since nothing above stores them
	always_comb begin
		case (bus.addr)
			REG_TIMER0: bus.rdata = 32'(timer0);
			REG_TIMER1: bus.rdata = 32'(timer1);
			REG_TOP0: bus.rdata = 32'(top0);
			REG_TOP1: bus.rdata = 32'(top1);
			REG_PRE0: bus.rdata = 32'(pre0);
			REG_PRE1: bus.rdata = 32'(pre1);
			REG_GPIO_DIR: bus.rdata = 32'(gpio_dir);
			REG_GPIO_DAT: bus.rdata = 32'(gpio_dat);
			REG_GPIO_PIN: bus.rdata = 32'(gpio_pins);
			REG_ALT: bus.rdata = 32'(alt);
			REG_INT_CTL: bus.rdata = 32'(irq_status); // ie, int2, int1, int0
			REG_SCRATCH: bus.rdata = scratch;
			REG_ID0: bus.rdata = ID0_VALUE;
			REG_ID1: bus.rdata = ID1_VALUE;
			default: bus.rdata = UNMAPPED_VALUE;
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/io_top.sv
`default_nettype none

module io_top #(
	parameter int TIMER_WIDTH = 32,
	parameter int PRESCALE_WIDTH = 17,
	parameter int GPIO_WIDTH = 8
) (
	input wire                       clk,
	input wire                       rst,
	input wire                       req,
	input wire                       we,
	input wire io_map_pkg::io_addr_t addr,
	input wire [31:0]                wdata,
	output logic                     ack,
	output logic [31:0]              rdata,
	input wire [GPIO_WIDTH-1:0]      gpio_in,
	output logic [GPIO_WIDTH-1:0]    gpio_out,
	output logic [GPIO_WIDTH-1:0]    gpio_oeb,
	output logic                     irq,
	output io_types_pkg::irq_vec_t   irq_vector,
	input wire                       int_taken,
	input wire                       int_return
);
	import io_map_pkg::*;

	logic [TIMER_WIDTH-1:0]    t0_count, t0_top, t1_count, t1_top;
	logic [PRESCALE_WIDTH-1:0] t0_pre, t1_pre;
	logic                      t0_wrap, t1_wrap;
	logic [GPIO_WIDTH-1:0]     gpio_dir;
	logic [7:0]                alt;
	logic                      pin_edge;
	logic [3:0]                irq_status;

	io_bus_if bus ();

	bus_slave_fsm u_fsm (.clk(clk), .rst(rst), .req(req), .we(we), .addr(addr),
		.wdata(wdata), .ack(ack), .rdata(rdata), .bus(bus.ctrl));

	prescaled_timer #(.TIMER_WIDTH(TIMER_WIDTH), .PRESCALE_WIDTH(PRESCALE_WIDTH),
		.COUNT_REG(REG_TIMER0), .TOP_REG(REG_TOP0), .PRE_REG(REG_PRE0)) u_timer0 (
		.clk(clk), .rst(rst), .bus(bus.peer), .count(t0_count), .top(t0_top),
		.prescaler(t0_pre), .wrap(t0_wrap));

	prescaled_timer #(.TIMER_WIDTH(TIMER_WIDTH), .PRESCALE_WIDTH(PRESCALE_WIDTH),
		.COUNT_REG(REG_TIMER1), .TOP_REG(REG_TOP1), .PRE_REG(REG_PRE1)) u_timer1 (
		.clk(clk), .rst(rst), .bus(bus.peer), .count(t1_count), .top(t1_top),
		.prescaler(t1_pre), .wrap(t1_wrap));

	gpio_port #(.GPIO_WIDTH(GPIO_WIDTH)) u_gpio (.clk(clk), .rst(rst), .bus(bus.peer),
		.alt(alt), .t1_wrap(t1_wrap), .pins(gpio_in), .dir(gpio_dir), .dat(gpio_out),
		.pin_edge(pin_edge));

	irq_ctrl u_irq (.clk(clk), .rst(rst), .bus(bus.peer), .alt(alt), .pin_edge(pin_edge),
		.t0_wrap(t0_wrap), .int_taken(int_taken), .int_return(int_return), .irq(irq),
		.irq_vector(irq_vector), .status(irq_status));

	io_regmap #(.GPIO_WIDTH(GPIO_WIDTH), .TIMER_WIDTH(TIMER_WIDTH),
		.PRESCALE_WIDTH(PRESCALE_WIDTH)) u_regmap (
		.clk(clk), .rst(rst), .bus(bus.map),
		.timer0(t0_count), .top0(t0_top), .pre0(t0_pre),
		.timer1(t1_count), .top1(t1_top), .pre1(t1_pre),
		.gpio_dir(gpio_dir), .gpio_dat(gpio_out), .gpio_pins(gpio_in),
		.irq_status(irq_status), .alt(alt));

	assign gpio_oeb = ~gpio_dir; // Low drives the pin

endmodule

`default_nettype wire

//--- sim/io_tb.sv
`default_nettype none

module io_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import io_map_pkg::*;
	import io_types_pkg::*;

	localparam int TIMER_WIDTH = 32;
	localparam int PRESCALE_WIDTH = 17;
	localparam int GPIO_WIDTH = 8;
	localparam int MAX_VEC = 64;

	logic                  clk, rst, req, we, ack, irq, int_taken, int_return;
	io_addr_t              addr;
	logic [31:0]           wdata, rdata;
	logic [GPIO_WIDTH-1:0] gpio_in, gpio_out, gpio_oeb;
	irq_vec_t              irq_vector;

	logic [31:0] vec_mem [0:4*MAX_VEC-1]; // Four words per vector
	int          n_vec = 0;
	int          longest_wait = 0;
	int          seed = 5067;

	io_top #(.TIMER_WIDTH(TIMER_WIDTH), .PRESCALE_WIDTH(PRESCALE_WIDTH),
		.GPIO_WIDTH(GPIO_WIDTH)) uut (
		.clk(clk), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
		.ack(ack), .rdata(rdata), .gpio_in(gpio_in), .gpio_out(gpio_out),
		.gpio_oeb(gpio_oeb), .irq(irq), .irq_vector(irq_vector),
		.int_taken(int_taken), .int_return(int_return));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s: expected 0x%08h, got 0x%08h", name, expected, actual));
	endtask

	task automatic check_vector(input string name, input irq_vec_t expected,
			input irq_vec_t actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s: expected vector %0d, got %0d", name, expected, actual));
	endtask

	task automatic check_gpio(input string name, input logic [GPIO_WIDTH-1:0] expected,
			input logic [GPIO_WIDTH-1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("ERROR %s: expected 0x%02h, got 0x%02h", name, expected, actual));
	endtask

	// One full four-phase handshake, returning the word seen while ack is high
	task automatic bus_xfer(input logic is_write, input io_addr_t index,
			input logic [31:0] data, output logic [31:0] result);
		@(posedge clk);
		req   <= 1'b1;
		we    <= is_write;
		addr  <= index;
		wdata <= data;
		@(negedge clk);
		while (!ack)
			@(negedge clk);
		result = rdata;
		@(posedge clk);
		req <= 1'b0;
		@(negedge clk);
		while (ack)
			@(negedge clk);
	endtask

	task automatic wait_irq(input int limit, input string name);
		int n;
		n = 0;
		@(negedge clk);
		while (!irq && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (!irq)
			abort_run($sformatf("%s: irq did not rise within %0d cycles", name, limit));
	endtask

	initial begin
		logic [31:0] op, data, expected, result, drawn;
		io_addr_t    index;
		logic        toggle_start;
		string       name;
		int          waited;
		int          found;
		rst        = 1'b1;
		req        = 1'b0;
		we         = 1'b0;
		addr       = '0;
		wdata      = '0;
		gpio_in    = '0;
		int_taken  = 1'b0;
		int_return = 1'b0;
		$readmemh("sim/io_vectors.txt", vec_mem);
		found = 0;
		while (found < MAX_VEC && vec_mem[4*found] != 32'h0) begin
			if ((vec_mem[4*found] == 32'h3 || vec_mem[4*found] == 32'hA) &&
					vec_mem[4*found+2] > longest_wait)
				longest_wait = vec_mem[4*found+2];
			found++;
		end
		if (found == 0)
			abort_run("No vectors could be read from sim/io_vectors.txt");
		n_vec = found;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		for (int i = 0; i < n_vec; i++) begin
			op       = vec_mem[4*i];
			index    = vec_mem[4*i+1][4:0];
			data     = vec_mem[4*i+2];
			expected = vec_mem[4*i+3];
			name     = $sformatf("vector %0d op %0h", i, op);
			case (op)
				32'h1: bus_xfer(1'b1, index, data, result);
				32'h2: begin
					bus_xfer(1'b0, index, '0, result);
					check_word(name, expected, result);
				end
				32'h3: begin
					wait_irq(data, name);
					check_vector(name, expected[1:0], irq_vector);
				end
				32'h4: begin
					@(posedge clk);
					gpio_in <= data[GPIO_WIDTH-1:0];
					repeat (4) @(posedge clk);
					gpio_in <= '0;
				end
				32'h5, 32'h6, 32'h7: begin // Ack, return or plain look at irq
					@(posedge clk);
					int_taken  <= (op == 32'h5);
					int_return <= (op == 32'h6);
					@(posedge clk);
					int_taken  <= 1'b0;
					int_return <= 1'b0;
					@(negedge clk);
					check_word(name, expected, 32'(irq));
				end
				32'h8: begin
					@(negedge clk);
					check_gpio({name, " gpio_out"}, data[GPIO_WIDTH-1:0], gpio_out);
					check_gpio({name, " gpio_oeb"}, expected[GPIO_WIDTH-1:0], gpio_oeb);
				end
				32'h9: begin
					@(posedge clk);
					gpio_in <= data[GPIO_WIDTH-1:0];
				end
				32'hA: begin
					@(negedge clk);
					toggle_start = gpio_out[TOGGLE_PIN];
					waited = 0;
					while (gpio_out[TOGGLE_PIN] == toggle_start && waited < data) begin
						@(negedge clk);
						waited++;
					end
					if (gpio_out[TOGGLE_PIN] == toggle_start)
						abort_run($sformatf("%s: gpio_out bit 0 did not toggle within %0d cycles",
							name, data));
				end
				32'hB: begin
					drawn = $random(seed);
					bus_xfer(1'b1, index, drawn, result);
					bus_xfer(1'b0, index, '0, result);
					check_word(name, drawn, result);
				end
				32'hC: begin
					bus_xfer(1'b0, index, '0, result);
					if (result > expected)
						abort_run($sformatf("ERROR %s: expected at most 0x%08h, got 0x%08h",
							name, expected, result));
				end
				default: abort_run($sformatf("Unknown operation %0h in vector %0d", op, i));
			endcase
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

	// Every vector gets a generous slice plus the longest timer wait in the file
	initial begin
		wait (n_vec > 0);
		repeat (n_vec * 200 + longest_wait) @(posedge clk);
		abort_run($sformatf("Timeout after %0d cycles, the vectors did not finish",
			n_vec * 200 + longest_wait));
	end

endmodule

`default_nettype wire

//--- sim/io_vectors.txt
// op addr data expected, hex, one vector per line, op 0 ends the list
// 1 wr, 2 rd, 3 wait-irq, 4 pin-pulse, 5 ack-irq, 6 return-irq, 7 irq, 8 gpio, 9 pins, A toggle
2 12 0 72696843
2 13 0 00002170
2 04 0 00000064
2 02 0 FFFFFFFF
2 0C 0 00000055
8 00 55 FF
2 1F 0 FFFFFFFF
B 11 0 0
1 0E A0 0
2 0E 0 A0
1 05 FFFE0064 0
2 05 0 00000064
1 12 0 0
2 12 0 72696843
1 0B 0F 0
1 0C A6 0
8 00 A6 F0
9 00 3C 0
2 0D 0 3C
1 02 1 0
1 00 0 0
1 0E 4 0
1 0F 18 0
3 00 12C 2
1 0E 0 0
1 0F 2 0
7 00 0 0
2 0F 0 8
1 0E 2 0
4 00 2 0
3 00 40 1
5 00 0 0
2 0F 0 1
6 00 0 1
1 0F 1 0
1 0F 4 0
3 00 40 3
1 03 1 0
1 01 0 0
1 0E 1 0
A 00 12C 0
C 01 0 1
0 0 0 0

//--- src.f
hdl/io_map_pkg.sv
hdl/io_types_pkg.sv
hdl/io_bus_if.sv
hdl/bus_slave_fsm.sv
hdl/prescaled_timer.sv
hdl/gpio_port.sv
hdl/irq_ctrl.sv
hdl/io_regmap.sv
hdl/io_top.sv
sim/io_tb.sv
